//--- design/rename_pkg.sv
package rename_pkg;

    // register file sizes
    localparam int ARCH_REG_NUM    = 32;
    localparam int PHYS_REG_NUM    = 64;
    localparam int FREE_LIST_DEPTH = PHYS_REG_NUM - ARCH_REG_NUM;

    // index widths derived from the sizes above
    localparam int ARCH_REG_W = $clog2(ARCH_REG_NUM);     // 5
    localparam int PHYS_REG_W = $clog2(PHYS_REG_NUM);     // 6
    localparam int FREE_PTR_W = $clog2(FREE_LIST_DEPTH);  // 5

    // architectural register index, r0 hardwired to zero
    typedef logic [ARCH_REG_W-1:0] arch_reg_t;

    // physical register index, p0 is the permanent home of r0
    typedef logic [PHYS_REG_W-1:0] phys_reg_t;

    // free list read / write pointer
    typedef logic [FREE_PTR_W-1:0] free_ptr_t;

    // free list occupancy, one extra bit so that a full list (32) fits
    typedef logic [FREE_PTR_W:0] free_count_t;

    // one rename request from the decoder
    typedef struct packed {
        arch_reg_t src1;
        arch_reg_t src2;
        arch_reg_t dest;
    } rename_req_t;

    // renamed operands, plus the mapping that dest replaces
    typedef struct packed {
        phys_reg_t src1;
        phys_reg_t src2;
        phys_reg_t dest;
        phys_reg_t dest_old;   // handed to the ROB, freed on commit
    } rename_resp_t;

endpackage

//--- design/rename_map_table.sv
`timescale 1ns/1ps

module rename_map_table import rename_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  rename_req_t  req,          // registered request, one stage cycle
    input  logic         alloc_valid,  // dest is written this cycle
    input  phys_reg_t    alloc_phys,   // new physical register from the free list
    output rename_resp_t resp
);

    // architectural to physical map
    phys_reg_t map [ARCH_REG_NUM];

    // identity mapping after reset, so ri lives in pi
    // the only write is the dest entry, at the end of the stage cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REG_NUM; i++) begin
                map[i] <= phys_reg_t'(i);
            end
        end else if (alloc_valid) begin
            map[req.dest] <= alloc_phys;
        end
    end

    // source lookup
    // a request that follows directly sees this write, since it is sampled
    // into the stage on the same edge as the map update
    always_comb begin
        resp.src1 = map[req.src1];
        resp.src2 = map[req.src2];
    end

    // destination side
    always_comb begin
        if (alloc_valid) begin
            resp.dest = alloc_phys;
        end else begin
            resp.dest = '0;                // no allocation, r0 or idle
        end
        resp.dest_old = map[req.dest];     // p0 for r0, it is never remapped
    end

    // r0 is filtered in the top, so entry 0 must never leave p0
    a_r0_maps_to_p0 : assert property (
        @(posedge clk) disable iff (reset)
        map[0] == '0
    ) else $error("map table entry 0 no longer holds p0");

endmodule

//--- design/free_list.sv
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      pop,        // allocation takes head_phys
    input  logic      push,       // commit release
    input  phys_reg_t push_phys,
    output phys_reg_t head_phys,  // next register to hand out
    output logic      empty
);

    // circular buffer of free physical registers
    phys_reg_t buffer [FREE_LIST_DEPTH];

    free_ptr_t   rd_ptr;
    free_ptr_t   wr_ptr;
    free_count_t count;
    logic        full;

    // depth is a power of two, pointers wrap by themselves

    assign empty     = (count == '0);
    assign full      = (count == free_count_t'(FREE_LIST_DEPTH));
    assign head_phys = buffer[rd_ptr];  // old value even if pushed this cycle

    // buffer contents
    // at reset it holds p32..p63 in ascending order, head first
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < FREE_LIST_DEPTH; i++) begin
                buffer[i] <= phys_reg_t'(ARCH_REG_NUM + i);
            end
        end else if (push) begin
            buffer[wr_ptr] <= push_phys;
        end
    end

    // read pointer
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // write pointer, starts on the head because the list is full
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= free_count_t'(FREE_LIST_DEPTH);
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // idle, or push and pop together
            endcase
        end
    end

    // upstream has to hold back nonzero dests while the list is empty,
    // including the one already in the stage
    a_no_pop_when_empty : assert property (
        @(posedge clk) disable iff (reset)
        pop |-> !empty
    ) else $error("free list popped while empty");

    // a full list already holds every unmapped register, so any
    // further release is a register freed twice
    a_no_push_when_full : assert property (
        @(posedge clk) disable iff (reset)
        push |-> !full
    ) else $error("free list pushed while full, double free of p%0d", push_phys);

endmodule

//--- design/register_rename.sv
`timescale 1ns/1ps

module register_rename import rename_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         rename_valid,  // strobe from the decoder
    input  rename_req_t  rename_req,
    input  logic         commit_valid,  // strobe from the ROB
    input  phys_reg_t    commit_phys,
    output logic         rename_done,
    output rename_resp_t rename_resp,
    output logic         free_empty
);

    // input stage
    logic        rename_valid_q;
    rename_req_t rename_req_q;
    logic        commit_valid_q;
    phys_reg_t   commit_phys_q;

    // stage controls
    logic      alloc;          // request with a real dest
    logic      release_valid;  // commit of a nonzero register
    phys_reg_t alloc_phys;

    // registered strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            rename_valid_q <= 1'b0;
            commit_valid_q <= 1'b0;
        end else begin
            rename_valid_q <= rename_valid;
            commit_valid_q <= commit_valid;
        end
    end

    always_ff @(posedge clk) begin
        rename_req_q  <= rename_req;
        commit_phys_q <= commit_phys;
    end

    // r0 is never renamed, this is the only place the test is made
    assign alloc = rename_valid_q && (rename_req_q.dest != '0);

    // p0 belongs to r0 for good and must never reach the free list
    assign release_valid = commit_valid_q && (commit_phys_q != '0);

    // one cycle from the sampling edge to a valid response
    assign rename_done = rename_valid_q;

    rename_map_table rename_map_table_inst (
        .clk         (clk),
        .reset       (reset),
        .req         (rename_req_q),
        .alloc_valid (alloc),
        .alloc_phys  (alloc_phys),
        .resp        (rename_resp)
    );

    free_list free_list_inst (
        .clk       (clk),
        .reset     (reset),
        .pop       (alloc),
        .push      (release_valid),
        .push_phys (commit_phys_q),
        .head_phys (alloc_phys),
        .empty     (free_empty)
    );

    // releasing the register handed out in the same stage cycle
    // is a double free, it still sits at the head
    a_commit_phys_legal : assert property (
        @(posedge clk) disable iff (reset)
        release_valid |-> !(alloc && (commit_phys_q == alloc_phys))
    ) else $error("illegal release of p%0d", commit_phys_q);

endmodule

//--- verif/rename_clock_gen.sv
`timescale 1ns/1ps

module rename_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 20;  // 40 ns clock
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // released just after an edge, in step with the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

//--- verif/register_rename_tb.sv
`timescale 1ns/1ps

module register_rename_tb import rename_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int RANDOM_REQS = 300;
    // driven cycles per group: reset, identity, r0, chain, fill, reuse, random
    localparam int TEST_CYCLES = 8 + 40 + 12 + 20 + 45 + 25 + RANDOM_REQS + 10;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * CLK_PERIOD;

    logic         clk;
    logic         reset;
    logic         rename_valid;
    rename_req_t  rename_req;
    logic         commit_valid;
    phys_reg_t    commit_phys;
    logic         rename_done;
    rename_resp_t rename_resp;
    logic         free_empty;

    // reference model
    phys_reg_t    model_map [ARCH_REG_NUM];
    phys_reg_t    model_free [$];
    rename_resp_t expect_q [$];
    phys_reg_t    release_pool [$];  // checked dest_old values, ready to commit

    integer seed;
    int     alloc_count;
    int     release_count;
    int     r0_count;
    int     held_count;

    rename_clock_gen clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    register_rename register_rename_inst (
        .clk          (clk),
        .reset        (reset),
        .rename_valid (rename_valid),
        .rename_req   (rename_req),
        .commit_valid (commit_valid),
        .commit_phys  (commit_phys),
        .rename_done  (rename_done),
        .rename_resp  (rename_resp),
        .free_empty   (free_empty)
    );

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_resp(input rename_resp_t got, input rename_resp_t exp,
                              input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %0d %0d %0d %0d, expected %0d %0d %0d %0d",
                     $time, what, got.src1, got.src2, got.dest, got.dest_old,
                     exp.src1, exp.src2, exp.dest, exp.dest_old);
            stop_on_failure();
        end
    endtask

    task automatic check_empty(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, free_empty is %b, expected %b",
                     $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // reset state: identity map, p32..p63 queued in order
    task automatic init_model();
        model_free.delete();
        for (int i = 0; i < ARCH_REG_NUM; i++) begin
            model_map[i] = phys_reg_t'(i);
        end
        for (int i = ARCH_REG_NUM; i < PHYS_REG_NUM; i++) begin
            model_free.push_back(phys_reg_t'(i));
        end
    endtask

    // expected response, from the model state before this request
    function automatic rename_resp_t ref_rename(input rename_req_t req);
        rename_resp_t r;
        r.src1     = model_map[req.src1];
        r.src2     = model_map[req.src2];
        r.dest     = (req.dest != '0) ? model_free[0] : '0;  // r0 is never renamed
        r.dest_old = model_map[req.dest];
        return r;
    endfunction

    function automatic rename_req_t make_req(input int s1, input int s2, input int d);
        rename_req_t r;
        r.src1 = arch_reg_t'(s1);
        r.src2 = arch_reg_t'(s2);
        r.dest = arch_reg_t'(d);
        return r;
    endfunction

    // sets the inputs for one cycle and updates the model to match
    task automatic drive_cycle(input logic rv, input rename_req_t req,
                               input logic cv, input phys_reg_t cp);
        rename_resp_t expected;
        rename_valid = rv;
        rename_req   = req;
        commit_valid = cv;
        commit_phys  = cp;
        if (rv) begin
            expected = ref_rename(req);
            expect_q.push_back(expected);
            if (req.dest != '0) begin
                model_map[req.dest] = expected.dest;
                model_free.delete(0);
                alloc_count++;
            end else begin
                r0_count++;
            end
        end
        // a release becomes visible to the request of the next cycle
        if (cv && cp != '0) begin
            model_free.push_back(cp);
            release_count++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b0, '0);
    endtask

    task automatic idle_check(input logic exp_empty, input string what);
        rename_valid = 1'b0;
        rename_req   = '0;
        commit_valid = 1'b0;
        commit_phys  = '0;
        @(negedge clk);
        check_empty(free_empty, exp_empty, what);
        @(posedge clk);
        #1;
    endtask

    // drain the stage, let the last release land, then compare the empty flag
    task automatic settle(input string what);
        while (expect_q.size() != 0) begin
            idle_cycle();
        end
        idle_cycle();
        idle_cycle();
        idle_check(model_free.size() == 0, what);
    endtask

    // compares each response in the middle of its stage cycle
    always @(negedge clk) begin : response_checker
        rename_resp_t expected;
        if (!reset && rename_done) begin
            if (expect_q.size() == 0) begin
                $display("rename_done went high at %0t with no rename pending", $time);
                stop_on_failure();
            end else begin
                expected = expect_q.pop_front();
                check_resp(rename_resp, expected, "rename response");
                if (expected.dest != '0) begin
                    release_pool.push_back(expected.dest_old);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the run did not finish in time", $time);
        stop_on_failure();
    end

    initial begin : stimulus
        logic [31:0] rnd;
        rename_req_t req;
        logic        rv;
        logic        cv;
        phys_reg_t   cp;

        rename_valid  = 1'b0;
        rename_req    = '0;
        commit_valid  = 1'b0;
        commit_phys   = '0;
        seed          = 77;
        alloc_count   = 0;
        release_count = 0;
        r0_count      = 0;
        held_count    = 0;
        init_model();
        @(negedge reset);

        // identity lookups, no destinations
        for (int i = 0; i < ARCH_REG_NUM; i++) begin
            drive_cycle(1'b1, make_req(i, ARCH_REG_NUM - 1 - i, 0), 1'b0, '0);
        end
        settle("free list after identity lookups");

        // r0 destinations leave map and list alone, read twice to see no change
        for (int k = 0; k < 2; k++) begin
            drive_cycle(1'b1, make_req(1, 2, 0), 1'b0, '0);
            drive_cycle(1'b1, make_req(3, 31, 0), 1'b0, '0);
            drive_cycle(1'b1, make_req(0, 0, 0), 1'b0, '0);
        end
        settle("free list after r0 destinations");

        // back to back dependent chain
        drive_cycle(1'b1, make_req(2, 3, 1), 1'b0, '0);
        drive_cycle(1'b1, make_req(1, 1, 4), 1'b0, '0);
        drive_cycle(1'b1, make_req(4, 1, 1), 1'b0, '0);
        drive_cycle(1'b1, make_req(1, 4, 0), 1'b0, '0);
        drive_cycle(1'b1, make_req(1, 7, 7), 1'b0, '0);
        drive_cycle(1'b1, make_req(7, 7, 7), 1'b0, '0);
        drive_cycle(1'b1, make_req(7, 1, 4), 1'b0, '0);
        settle("free list after dependent chain");

        // use up the rest of the list with no commits
        for (int k = 0; model_free.size() > 0; k++) begin
            drive_cycle(1'b1, make_req(k % 32, (k * 7) % 32, (k % 31) + 1), 1'b0, '0);
        end
        settle("free list after 32 allocations");

        // one release, seen one cycle after it is sampled
        drive_cycle(1'b0, '0, 1'b1, release_pool.pop_front());
        idle_check(1'b1, "empty flag before the release is pushed");
        idle_check(1'b0, "empty flag after the release is pushed");

        // more releases and a p0 commit, then reuse in FIFO order
        for (int k = 0; k < 3; k++) begin
            drive_cycle(1'b0, '0, 1'b1, release_pool.pop_front());
        end
        drive_cycle(1'b0, '0, 1'b1, '0);
        for (int k = 0; k < 4; k++) begin
            drive_cycle(1'b1, make_req(k + 8, k + 1, k + 10), 1'b0, '0);
        end
        settle("free list after reuse, p0 must not be queued");

        // random mix
        for (int n = 0; n < RANDOM_REQS; n++) begin
            rnd = $random(seed);
            req = rnd[14:0];
            rv  = (($random(seed) & 3) != 0);
            if (rv && req.dest != '0 && model_free.size() == 0) begin
                req.dest = '0;  // hold back while the list is empty
                held_count++;
            end
            cv = 1'b0;
            cp = '0;
            if (release_pool.size() > 0 && model_free.size() < FREE_LIST_DEPTH &&
                ($random(seed) & 1) != 0) begin
                cv = 1'b1;
                cp = release_pool.pop_front();
            end else if (($random(seed) & 15) == 0) begin
                cv = 1'b1;  // stray p0 commit
            end
            drive_cycle(rv, req, cv, cp);
        end
        settle("free list after random mix");

        $display("allocations %0d, releases %0d, r0 renames %0d, held back %0d",
                 alloc_count, release_count, r0_count, held_count);
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- register_rename.f
design/rename_pkg.sv
design/rename_map_table.sv
design/free_list.sv
design/register_rename.sv
verif/rename_clock_gen.sv
verif/register_rename_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the register rename testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

TOP=register_rename_tb
OBJ_DIR=obj_dir
PASS_TEXT="Test completed successfully"

verilator --binary --timing --assert -sv \
    --top-module "$TOP" \
    -f register_rename.f \
    --Mdir "$OBJ_DIR" \
    -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$("./$OBJ_DIR/V$TOP" 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^${PASS_TEXT}\$"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
